/* hdl/noc_pkg.sv */
/*
 * Shared types for the mesh network interface and its testbench.
 * Defines coordinates, directions, flit kinds and the flit layout.
 * Import with a wildcard inside a module body.
 */
package noc_pkg;

  // Bus widths of the local Wishbone side
  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;

  // One mesh coordinate, up to 8 nodes per dimension
  typedef logic [2:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } node_id_t;

  // Output port of the first hop
  typedef enum logic [2:0] {
    DirLocal = 3'd0,
    DirEast  = 3'd1,
    DirWest  = 3'd2,
    DirNorth = 3'd3,
    DirSouth = 3'd4
  } dir_e;

  typedef enum logic [1:0] {
    KindWrReq = 2'd0,
    KindRdReq = 2'd1,
    KindRsp   = 2'd2
  } kind_e;

  typedef logic [3:0] tag_t;

  typedef struct packed {
    node_id_t dst;
    node_id_t src;
    kind_e    kind;
    tag_t     tag;
  } flit_hdr_t;

  // Request view of the body
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } req_body_t;

  // Response view, padded to the request size
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
    logic [30:0]          pad;
  } rsp_body_t;

  // Same 64 bits, read as request or as response depending on kind
  typedef union packed {
    req_body_t req;
    rsp_body_t rsp;
  } flit_body_u;

  typedef struct packed {
    flit_hdr_t  hdr;
    flit_body_u body;
  } flit_t;

endpackage

/* hdl/ni_cfg_pkg.sv */
/*
 * Configuration of the network interface address decoding.
 * Holds the routing algorithm choice and the default address map.
 */
package ni_cfg_pkg;

  // How an address is turned into a destination node
  typedef enum logic {
    RouteTable  = 1'b0,
    RouteXyBits = 1'b1
  } route_algo_e;

  // One address window, end address is exclusive
  typedef struct packed {
    logic [31:0]       start_addr;
    logic [31:0]       end_addr;
    noc_pkg::node_id_t id;
  } addr_rule_t;

  parameter int unsigned NumRules = 4;

  // Four 16 MiB windows at the bottom of the address space
  parameter addr_rule_t [NumRules-1:0] DefaultAddrMap = '{
    '{start_addr: 32'h0300_0000, end_addr: 32'h0400_0000,
      id: '{x: 3'd3, y: 3'd3}},
    '{start_addr: 32'h0200_0000, end_addr: 32'h0300_0000,
      id: '{x: 3'd0, y: 3'd2}},
    '{start_addr: 32'h0100_0000, end_addr: 32'h0200_0000,
      id: '{x: 3'd2, y: 3'd1}},
    '{start_addr: 32'h0000_0000, end_addr: 32'h0100_0000,
      id: '{x: 3'd1, y: 3'd0}}
  };

  // Bit positions of the coordinates for XY-bit routing
  parameter int unsigned DefaultOffsetX = 24;
  parameter int unsigned DefaultOffsetY = 28;

endpackage

/* hdl/noc_req_if.sv */
/*
 * Decoded request from the controller to the flit packer.
 * Transfer on valid and ready; ready means the packer is empty.
 */
`timescale 1ns/10ps

interface noc_req_if;
  import noc_pkg::*;

  logic                 valid;
  logic                 ready;
  kind_e                kind;
  tag_t                 tag;
  node_id_t             dst;
  // First hop, already resolved by the route computation
  dir_e                 dir;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;

  modport ctrl (
    output valid, kind, tag, dst, dir, addr, wdata,
    input  ready
  );

  modport pack (
    input  valid, kind, tag, dst, dir, addr, wdata,
    output ready
  );

endinterface

/* hdl/noc_route_comp.sv */
/*
 * Combinational route computation for one request address.
 * Gives the destination node, a decode error and the XY first hop.
 */
`timescale 1ns/10ps

module noc_route_comp #(
  parameter ni_cfg_pkg::route_algo_e RouteAlgo = ni_cfg_pkg::RouteTable,
  parameter int unsigned NodeX   = 0,
  parameter int unsigned NodeY   = 0,
  parameter int unsigned MeshX   = 4,
  parameter int unsigned MeshY   = 4,
  parameter int unsigned OffsetX = ni_cfg_pkg::DefaultOffsetX,
  parameter int unsigned OffsetY = ni_cfg_pkg::DefaultOffsetY
) (
  input  logic [noc_pkg::AddrWidth-1:0] addr_i,
  output noc_pkg::node_id_t             dst_o,
  output noc_pkg::dir_e                 dir_o,
  output logic                          dec_error_o
);
  import noc_pkg::*;
  import ni_cfg_pkg::*;

  node_id_t dst;
  logic     dec_error;

  if (RouteAlgo == RouteTable) begin : gen_table
    // First matching rule wins
    always_comb begin
      logic found;
      found = 1'b0;
      dst   = '0;
      for (int i = 0; i < NumRules; i++) begin
        if (!found &&
            addr_i >= DefaultAddrMap[i].start_addr &&
            addr_i <  DefaultAddrMap[i].end_addr) begin
          dst   = DefaultAddrMap[i].id;
          found = 1'b1;
        end
      end
      dec_error = !found;
    end
  end else begin : gen_xy_bits
    // Coordinates sit directly in the address
    assign dst.x = addr_i[OffsetX +: $bits(coord_t)];
    assign dst.y = addr_i[OffsetY +: $bits(coord_t)];
    // Nodes outside the mesh do not exist
    assign dec_error = (32'(dst.x) >= MeshX) || (32'(dst.y) >= MeshY);
  end

  // Dimension order routing, resolve x before y
  // North is the direction of growing y
  always_comb begin
    if (32'(dst.x) > NodeX) begin
      dir_o = DirEast;
    end else if (32'(dst.x) < NodeX) begin
      dir_o = DirWest;
    end else if (32'(dst.y) > NodeY) begin
      dir_o = DirNorth;
    end else if (32'(dst.y) < NodeY) begin
      dir_o = DirSouth;
    end else begin
      // Target is this node
      dir_o = DirLocal;
    end
  end

  assign dst_o       = dst;
  assign dec_error_o = dec_error;

endmodule

/* hdl/noc_flit_pack.sv */
/*
 * Request flit packer with a one-entry output register.
 * Takes a decoded request and holds the flit until the network takes it.
 */
`timescale 1ns/10ps

module noc_flit_pack #(
  parameter int unsigned NodeX = 0,
  parameter int unsigned NodeY = 0
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  noc_req_if.pack         req,
  output logic            req_valid_o,
  input  logic            req_ready_i,
  output noc_pkg::flit_t  req_flit_o,
  output noc_pkg::dir_e   req_dir_o
);
  import noc_pkg::*;

  flit_t flit_d;
  logic  load;

  // Only an empty register takes a new request
  assign req.ready = !req_valid_o;
  assign load      = req.valid && req.ready;

  // Header plus request view of the body
  always_comb begin
    flit_d               = '0;
    flit_d.hdr.dst       = req.dst;
    flit_d.hdr.src.x     = coord_t'(NodeX);
    flit_d.hdr.src.y     = coord_t'(NodeY);
    flit_d.hdr.kind      = req.kind;
    flit_d.hdr.tag       = req.tag;
    flit_d.body.req.addr  = req.addr;
    flit_d.body.req.wdata = req.wdata;
  end

  // Valid flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_valid_o <= 1'b0;
    end else if (load) begin
      req_valid_o <= 1'b1;
    end else if (req_valid_o && req_ready_i) begin
      // Handshake done, register is free again
      req_valid_o <= 1'b0;
    end
  end

  // Payload stays put while valid is high
  always_ff @(posedge clk_i) begin
    if (load) begin
      req_flit_o <= flit_d;
      req_dir_o  <= req.dir;
    end
  end

endmodule

/* hdl/noc_rsp_unpack.sv */
/*
 * Response flit receiver for the single outstanding read.
 * Consumes flits while armed and flags the one that matches node and tag.
 */
`timescale 1ns/10ps

module noc_rsp_unpack #(
  parameter int unsigned NodeX = 0,
  parameter int unsigned NodeY = 0
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          armed_i,
  input  noc_pkg::tag_t                 exp_tag_i,
  input  logic                          rsp_valid_i,
  output logic                          rsp_ready_o,
  input  noc_pkg::flit_t                rsp_flit_i,
  output logic                          done_o,
  output logic [noc_pkg::DataWidth-1:0] rdata_o,
  output logic                          rsp_err_o
);
  import noc_pkg::*;

  logic accept;
  logic match;

  // Stop taking flits once the answer is in hand
  assign rsp_ready_o = armed_i && !done_o;
  assign accept      = rsp_valid_i && rsp_ready_o;

  // Right kind, right node, right tag
  assign match = accept &&
                 rsp_flit_i.hdr.kind == KindRsp &&
                 32'(rsp_flit_i.hdr.dst.x) == NodeX &&
                 32'(rsp_flit_i.hdr.dst.y) == NodeY &&
                 rsp_flit_i.hdr.tag == exp_tag_i;

  // Non-matching flits are simply dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= match;
    end
  end

  // Read data through the response view, kept until the next match
  always_ff @(posedge clk_i) begin
    if (match) begin
      rdata_o   <= rsp_flit_i.body.rsp.rdata;
      rsp_err_o <= rsp_flit_i.body.rsp.err;
    end
  end

endmodule

/* hdl/noc_ni_ctrl.sv */
/*
 * Wishbone classic slave control of the network interface.
 * Samples one request, hands it to the packer and waits for completion.
 * Only one transaction is in flight at a time.
 */
`timescale 1ns/10ps

module noc_ni_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [noc_pkg::AddrWidth-1:0]   adr_i,
  input  logic [noc_pkg::DataWidth-1:0]   dat_i,
  input  logic [noc_pkg::DataWidth/8-1:0] sel_i,
  output logic [noc_pkg::DataWidth-1:0]   dat_o,
  output logic                            ack_o,
  output logic                            err_o,
  output logic [noc_pkg::AddrWidth-1:0]   route_addr_o,
  input  noc_pkg::node_id_t               route_dst_i,
  input  noc_pkg::dir_e                   route_dir_i,
  input  logic                            route_err_i,
  noc_req_if.ctrl                         req,
  output logic                            armed_o,
  output noc_pkg::tag_t                   exp_tag_o,
  input  logic                            done_i,
  input  logic [noc_pkg::DataWidth-1:0]   rdata_i,
  input  logic                            rsp_err_i
);
  import noc_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StIssue,
    StWaitSent,
    StWaitRsp
  } state_e;

  state_e               state_q;
  logic                 start;
  logic                 dec_err_q;
  kind_e                kind_q;
  tag_t                 tag_q;
  tag_t                 tag_cnt_q;
  logic [AddrWidth-1:0] addr_q;
  logic [DataWidth-1:0] wdata_q;
  logic [DataWidth-1:0] wdata_masked;

  // New request, but not the one just answered with a decode error
  assign start = state_q == StIdle && cyc_i && stb_i && !dec_err_q;

  // Unselected byte lanes go out as zero
  always_comb begin
    for (int b = 0; b < DataWidth / 8; b++) begin
      wdata_masked[b*8 +: 8] = sel_i[b] ? dat_i[b*8 +: 8] : 8'h00;
    end
  end

  // Decode straight from the bus when idle, later from the held address
  assign route_addr_o = (state_q == StIdle) ? adr_i : addr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= StIdle;
      dec_err_q <= 1'b0;
      tag_cnt_q <= '0;
    end else begin
      dec_err_q <= start && route_err_i;
      case (state_q)
        StIdle: begin
          if (start && !route_err_i) begin
            state_q <= StIssue;
            // Reads take a fresh tag
            if (!we_i) begin
              tag_cnt_q <= tag_cnt_q + 1'b1;
            end
          end
        end
        StIssue: begin
          if (req.ready) begin
            state_q <= StWaitSent;
          end
        end
        StWaitSent: begin
          // Packer empty again means the flit left
          if (req.ready) begin
            state_q <= (kind_q == KindRdReq) ? StWaitRsp : StIdle;
          end
        end
        StWaitRsp: begin
          if (done_i) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Request payload, held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q  <= adr_i;
      wdata_q <= wdata_masked;
      kind_q  <= we_i ? KindWrReq : KindRdReq;
      // Writes always carry tag zero
      tag_q   <= we_i ? '0 : tag_cnt_q;
    end
  end

  // Handoff to the packer
  assign req.valid = state_q == StIssue;
  assign req.kind  = kind_q;
  assign req.tag   = tag_q;
  assign req.dst   = route_dst_i;
  assign req.dir   = route_dir_i;
  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;

  // Response matching
  assign armed_o   = state_q == StWaitRsp;
  assign exp_tag_o = tag_q;

  // Bus answer, one cycle each
  always_comb begin
    ack_o = 1'b0;
    err_o = dec_err_q;
    if (state_q == StWaitSent && req.ready && kind_q == KindWrReq) begin
      ack_o = 1'b1;
    end
    if (state_q == StWaitRsp && done_i) begin
      ack_o = !rsp_err_i;
      err_o = rsp_err_i;
    end
  end

  // Read data register sits in the unpacker and holds until the next read
  assign dat_o = rdata_i;

endmodule

/* hdl/noc_ni_top.sv */
/*
 * Top level of the mesh network interface.
 * Wishbone slave in, request flits out, response flits back in.
 */
`timescale 1ns/10ps

module noc_ni_top #(
  parameter ni_cfg_pkg::route_algo_e RouteAlgo = ni_cfg_pkg::RouteTable,
  parameter int unsigned NodeX   = 1,
  parameter int unsigned NodeY   = 1,
  parameter int unsigned MeshX   = 4,
  parameter int unsigned MeshY   = 4,
  parameter int unsigned OffsetX = ni_cfg_pkg::DefaultOffsetX,
  parameter int unsigned OffsetY = ni_cfg_pkg::DefaultOffsetY
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Wishbone classic slave
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [noc_pkg::AddrWidth-1:0]   adr_i,
  input  logic [noc_pkg::DataWidth-1:0]   dat_i,
  input  logic [noc_pkg::DataWidth/8-1:0] sel_i,
  output logic [noc_pkg::DataWidth-1:0]   dat_o,
  output logic                            ack_o,
  output logic                            err_o,
  // Request flits to the router
  output logic                            req_valid_o,
  input  logic                            req_ready_i,
  output noc_pkg::flit_t                  req_flit_o,
  output noc_pkg::dir_e                   req_dir_o,
  // Response flits from the router
  input  logic                            rsp_valid_i,
  output logic                            rsp_ready_o,
  input  noc_pkg::flit_t                  rsp_flit_i
);
  import noc_pkg::*;

  logic [AddrWidth-1:0] route_addr;
  node_id_t             route_dst;
  dir_e                 route_dir;
  logic                 route_err;
  logic                 armed;
  tag_t                 exp_tag;
  logic                 done;
  logic [DataWidth-1:0] rdata;
  logic                 rsp_err;

  noc_req_if u_req_if ();

  noc_ni_ctrl u_ctrl (
    .clk_i, .rst_n_i, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i,
    .dat_o, .ack_o, .err_o,
    .route_addr_o (route_addr),
    .route_dst_i  (route_dst),
    .route_dir_i  (route_dir),
    .route_err_i  (route_err),
    .req          (u_req_if.ctrl),
    .armed_o      (armed),
    .exp_tag_o    (exp_tag),
    .done_i       (done),
    .rdata_i      (rdata),
    .rsp_err_i    (rsp_err)
  );

  noc_route_comp #(
    .RouteAlgo (RouteAlgo), .NodeX (NodeX), .NodeY (NodeY),
    .MeshX (MeshX), .MeshY (MeshY), .OffsetX (OffsetX), .OffsetY (OffsetY)
  ) u_route_comp (
    .addr_i      (route_addr),
    .dst_o       (route_dst),
    .dir_o       (route_dir),
    .dec_error_o (route_err)
  );

  noc_flit_pack #(.NodeX (NodeX), .NodeY (NodeY)) u_flit_pack (
    .clk_i, .rst_n_i,
    .req (u_req_if.pack),
    .req_valid_o, .req_ready_i, .req_flit_o, .req_dir_o
  );

  noc_rsp_unpack #(.NodeX (NodeX), .NodeY (NodeY)) u_rsp_unpack (
    .clk_i, .rst_n_i,
    .armed_i   (armed),
    .exp_tag_i (exp_tag),
    .rsp_valid_i, .rsp_ready_o, .rsp_flit_i,
    .done_o    (done),
    .rdata_o   (rdata),
    .rsp_err_o (rsp_err)
  );

endmodule

/* test/noc_ni_assertions.sv */
/*
 * Protocol checks on the ports of the network interface top level.
 * Bound into noc_ni_top, so the checks run wherever the top is simulated.
 */
`timescale 1ns/10ps

module noc_ni_assertions (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           cyc_i,
  input logic           stb_i,
  input logic           ack_i,
  input logic           err_i,
  input logic           req_valid_i,
  input logic           req_ready_i,
  input noc_pkg::flit_t req_flit_i,
  input noc_pkg::dir_e  req_dir_i,
  input logic           rsp_ready_i
);

  // One flag per property, readable from the testbench
  logic flit_moved = 1'b0;
  logic both_high  = 1'b0;
  logic ack_long   = 1'b0;
  logic err_long   = 1'b0;
  logic no_request = 1'b0;
  logic not_idle   = 1'b0;
  logic fail_seen;

  assign fail_seen = flit_moved | both_high | ack_long | err_long | no_request | not_idle;

  // Flit and direction frozen while the network stalls
  a_flit_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_flit_i) && $stable(req_dir_i))
    else begin
      $error("request flit changed or dropped under back-pressure");
      flit_moved = 1'b1;
    end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_i && err_i))
    else begin
      $error("ack and err high in the same cycle");
      both_high = 1'b1;
    end

  // Single cycle answers
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i |=> !ack_i)
    else begin
      $error("ack held longer than one cycle");
      ack_long = 1'b1;
    end

  a_err_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_i |=> !err_i)
    else begin
      $error("err held longer than one cycle");
      err_long = 1'b1;
    end

  // An answer needs an open bus cycle
  a_answer_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i || err_i |-> cyc_i && stb_i)
    else begin
      $error("answer given without cyc and stb");
      no_request = 1'b1;
    end

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !ack_i && !err_i && !req_valid_i && !rsp_ready_i)
    else begin
      $error("control outputs not low after reset");
      not_idle = 1'b1;
    end

endmodule

/* test/tb_noc_ni.sv */
/*
 * Testbench for the mesh network interface at node (1,1) of a 4x4 mesh.
 * Issues Wishbone reads and writes, stalls the request port at random and
 * answers reads, sometimes after a stale flit. Assertions compare flits and
 * bus answers with a model of the default address map.
 */
`timescale 1ns/10ps

module tb_noc_ni;
  import noc_pkg::*;
  import ni_cfg_pkg::*;

  localparam int unsigned NodeX         = 1;
  localparam int unsigned NodeY         = 1;
  localparam int unsigned NumTxns       = 40;
  localparam int unsigned ResetCycles   = 10;
  localparam int unsigned TimeoutCycles = ResetCycles + NumTxns * 64;
  localparam logic [15:0] Seed          = 16'd25440;
  localparam node_id_t    OwnId         = '{x: 3'(NodeX), y: 3'(NodeY)};

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   cyc_i;
  logic                   stb_i;
  logic                   we_i;
  logic [AddrWidth-1:0]   adr_i;
  logic [DataWidth-1:0]   dat_i;
  logic [DataWidth/8-1:0] sel_i;
  logic [DataWidth-1:0]   dat_o;
  logic                   ack_o;
  logic                   err_o;
  logic                   req_valid_o;
  logic                   req_ready_i;
  flit_t                  req_flit_o;
  dir_e                   req_dir_o;
  logic                   rsp_valid_i;
  logic                   rsp_ready_o;
  flit_t                  rsp_flit_i;

  // Current bus request and responder state
  logic                 cur_we;
  logic [AddrWidth-1:0] cur_adr;
  logic [DataWidth-1:0] cur_dat;
  int                   flits_sent;
  flit_t                sent_flit;
  logic                 stale_todo;
  logic                 good_driven;
  logic                 good_taken;
  logic                 rsp_ready_seen;
  tag_t                 rd_tag;
  logic [15:0]          lfsr_q;
  int unsigned          cycle_cnt = 0;

  // Expected values from the address map
  logic     exp_hit;
  node_id_t exp_dst;
  dir_e     exp_dir;
  kind_e    exp_kind;
  tag_t     exp_tag;
  logic     bound_fail;

  noc_ni_top #(
    .RouteAlgo (RouteTable), .NodeX (NodeX), .NodeY (NodeY), .MeshX (4), .MeshY (4)
  ) u_noc_ni_top (
    .clk_i, .rst_n_i, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i,
    .dat_o, .ack_o, .err_o,
    .req_valid_o, .req_ready_i, .req_flit_o, .req_dir_o,
    .rsp_valid_i, .rsp_ready_o, .rsp_flit_i
  );

  bind noc_ni_top noc_ni_assertions u_noc_ni_assertions (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .cyc_i (cyc_i), .stb_i (stb_i),
    .ack_i (ack_o), .err_i (err_o),
    .req_valid_i (req_valid_o), .req_ready_i (req_ready_i),
    .req_flit_i (req_flit_o), .req_dir_i (req_dir_o), .rsp_ready_i (rsp_ready_o)
  );

  assign bound_fail = u_noc_ni_top.u_noc_ni_assertions.fail_seen;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic value_error(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    $display("FAIL %s got %h expected %h", name, got, exp);
    $display("TEST FAIL");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic rule_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "%s", what);
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Address map model, windows do not overlap
  always_comb begin
    exp_hit = 1'b0;
    exp_dst = '0;
    for (int i = 0; i < NumRules; i++) begin
      if (cur_adr >= DefaultAddrMap[i].start_addr && cur_adr < DefaultAddrMap[i].end_addr) begin
        exp_hit = 1'b1;
        exp_dst = DefaultAddrMap[i].id;
      end
    end
  end

  // XY order against this node, north means larger y
  function automatic dir_e xy_first_hop(node_id_t d);
    if (d.x != OwnId.x) begin
      return (d.x > OwnId.x) ? DirEast : DirWest;
    end
    if (d.y != OwnId.y) begin
      return (d.y > OwnId.y) ? DirNorth : DirSouth;
    end
    return DirLocal;
  endfunction

  assign exp_dir  = xy_first_hop(exp_dst);
  assign exp_kind = cur_we ? KindWrReq : KindRdReq;
  // Writes carry tag zero, reads count up from zero after reset
  assign exp_tag  = cur_we ? '0 : rd_tag;

  // Response to a read request, stale ones carry the next tag
  function automatic flit_t make_rsp(flit_t rq, logic stale);
    flit_t f;
    f                = '0;
    f.hdr.dst        = rq.hdr.src;
    f.hdr.src        = rq.hdr.dst;
    f.hdr.kind       = KindRsp;
    f.hdr.tag        = stale ? rq.hdr.tag + 4'd1 : rq.hdr.tag;
    f.body.rsp.rdata = ~rq.body.req.addr;
    return f;
  endfunction

  // Flit content while valid
  a_flit_dst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_flit_o.hdr.dst == exp_dst)
    else value_error("req_flit_o.hdr.dst", 64'($sampled(req_flit_o.hdr.dst)), 64'(exp_dst));
  a_flit_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_flit_o.hdr.src == OwnId)
    else value_error("req_flit_o.hdr.src", 64'($sampled(req_flit_o.hdr.src)), 64'(OwnId));
  a_flit_kind: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_flit_o.hdr.kind == exp_kind)
    else value_error("req_flit_o.hdr.kind", 64'($sampled(req_flit_o.hdr.kind)), 64'(exp_kind));
  a_flit_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_flit_o.hdr.tag == exp_tag)
    else value_error("req_flit_o.hdr.tag", 64'($sampled(req_flit_o.hdr.tag)), 64'(exp_tag));
  a_flit_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_flit_o.body.req.addr == cur_adr)
    else value_error("req_flit_o.body.req.addr", 64'($sampled(req_flit_o.body.req.addr)),
                     64'(cur_adr));
  a_flit_wdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o && cur_we |-> req_flit_o.body.req.wdata == cur_dat)
    else value_error("req_flit_o.body.req.wdata", 64'($sampled(req_flit_o.body.req.wdata)),
                     64'(cur_dat));
  a_flit_dir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> req_dir_o == exp_dir)
    else value_error("req_dir_o", 64'($sampled(req_dir_o)), 64'(exp_dir));
  a_no_flit_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> exp_hit)
    else rule_error("request flit sent for an unmapped address");
  a_no_duplicate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flits_sent <= 1)
    else rule_error("more than one flit sent for one bus request");

  // Bus answers
  a_ack_after_flit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o |-> exp_hit && flits_sent == 1)
    else rule_error("ack given without exactly one flit sent for a mapped address");
  a_read_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o && !cur_we |-> dat_o == ~cur_adr)
    else value_error("dat_o", 64'($sampled(dat_o)), 64'(~cur_adr));
  a_no_stale_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o && !cur_we |-> good_taken)
    else rule_error("read acknowledged before the matching response arrived");
  a_err_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_o |-> !exp_hit && flits_sent == 0)
    else rule_error("err given for a mapped address or after a flit");

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      rule_error("timeout, the bus transactions did not finish in time");
    end
  end

  always @(negedge clk_i) begin
    if (bound_fail) begin
      rule_error("a protocol assertion on the DUT ports failed");
    end
  end

  // One cycle of network side activity, ends on a falling edge
  task automatic clock_step();
    logic [31:0] r;
    @(negedge clk_i);
    // Offered response went in at the last rising edge
    if (rsp_valid_i && rsp_ready_seen) begin
      rsp_valid_i = 1'b0;
      if (rsp_flit_i.hdr.tag == sent_flit.hdr.tag) begin
        good_taken = 1'b1;
      end
    end
    // Random stall of the request port
    draw_bits(1, r);
    req_ready_i = r[0];
    if (req_valid_o && req_ready_i) begin
      sent_flit  = req_flit_o;
      flits_sent = flits_sent + 1;
    end
    // Answer a waiting read
    if (rsp_ready_o && !rsp_valid_i && !good_driven) begin
      rsp_flit_i  = make_rsp(sent_flit, stale_todo);
      rsp_valid_i = 1'b1;
      if (stale_todo) begin
        stale_todo = 1'b0;
      end else begin
        good_driven = 1'b1;
      end
    end
    rsp_ready_seen = rsp_ready_o;
  endtask

  task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] r;
    cur_we      = we;
    cur_adr     = adr;
    cur_dat     = dat;
    flits_sent  = 0;
    good_driven = 1'b0;
    good_taken  = 1'b0;
    stale_todo  = 1'b0;
    if (!we) begin
      draw_bits(1, r);
      stale_todo = r[0];
    end
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = dat;
    sel_i = '1;
    // Master holds the request until an answer shows up
    do begin
      clock_step();
    end while (!(ack_o || err_o));
    // Answer is taken at the next rising edge
    clock_step();
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    // Every mapped read used up one tag
    if (!we && exp_hit) begin
      rd_tag = rd_tag + 1'b1;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] adr;
    logic [31:0] dat;
    int          region;
    rst_n_i        = 1'b0;
    cyc_i          = 1'b0;
    stb_i          = 1'b0;
    we_i           = 1'b0;
    adr_i          = '0;
    dat_i          = '0;
    sel_i          = '0;
    req_ready_i    = 1'b0;
    rsp_valid_i    = 1'b0;
    rsp_flit_i     = '0;
    sent_flit      = '0;
    cur_we         = 1'b0;
    cur_adr        = '0;
    cur_dat        = '0;
    flits_sent     = 0;
    stale_todo     = 1'b0;
    good_driven    = 1'b0;
    good_taken     = 1'b0;
    rsp_ready_seen = 1'b0;
    rd_tag         = '0;
    lfsr_q         = Seed;
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;
    clock_step();
    // Four mapped windows and one unmapped slot, reads and writes alternate
    for (int i = 0; i < NumTxns; i++) begin
      region = i % 5;
      draw_bits(26, r);
      if (region < 4) begin
        adr = DefaultAddrMap[region].start_addr + {8'h00, r[23:0]};
      end else begin
        adr = {r[25:0], 6'h00} | 32'h0400_0000;
      end
      draw_bits(32, dat);
      wb_transfer(i % 2 == 0, adr, dat);
      clock_step();
    end
    if (bound_fail) begin
      rule_error("a protocol assertion on the DUT ports failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* verilog.f */
hdl/noc_pkg.sv
hdl/ni_cfg_pkg.sv
hdl/noc_req_if.sv
hdl/noc_route_comp.sv
hdl/noc_flit_pack.sv
hdl/noc_rsp_unpack.sv
hdl/noc_ni_ctrl.sv
hdl/noc_ni_top.sv
test/noc_ni_assertions.sv
test/tb_noc_ni.sv

/* run.sh */
#!/bin/sh
# Compile and run the network interface testbench with Verilator.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
  echo "cannot create build directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noc_ni -Mdir build -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./build/Vtb_noc_ni +verilator+error+limit+100 > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" build/sim.log; then
  exit 0
fi
echo "pass line not found in build/sim.log"
exit 1
